/* hdl/rom_addr_counter.sv */
/*
  Up counter with a redundant complemented shadow copy.
  Supplies the ROM address and the compare index.
  err_o flags any disagreement between the two copies.
*/
`default_nettype none

module rom_addr_counter #(
  parameter int unsigned Width = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clr_i,
  input  logic             incr_i,
  output logic [Width-1:0] cnt_o,
  output logic             err_o
);

  logic [Width-1:0] cnt_q;
  // Holds the bitwise inverse of cnt_q
  logic [Width-1:0] shadow_q;

  // Primary count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (incr_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Shadow steps down, so it stays the complement of the count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '1;
    end else if (clr_i) begin
      shadow_q <= '1;
    end else if (incr_i) begin
      shadow_q <= shadow_q - 1'b1;
    end
  end

  assign cnt_o = cnt_q;

  // Any glitch or fault on either copy shows up here
  assign err_o = (cnt_q != ~shadow_q);

  // Control never asks to clear and step in the same cycle
  ClrIncrExclusive_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(clr_i && incr_i)
  ) else $error("counter clr_i and incr_i both high");

endmodule

`default_nettype wire

/* hdl/rom_check_fsm.sv */
/*
  Control for the ROM checker.
  Reads every ROM word after start_i, waits for the last word,
  walks the digest lanes for the compare and then parks in Done.
  Consistency checks on state and counter feed a sticky alert.
*/
`default_nettype none

module rom_check_fsm
  import rom_check_pkg::*;
#(
  parameter int unsigned RomDepth       = 16,
  parameter int unsigned NumDigestWords = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  logic [$clog2(RomDepth)-1:0] cnt_i,
  input  logic                        cnt_err_i,
  output logic                        cnt_clr_o,
  output logic                        cnt_incr_o,
  output logic                        rom_req_o,
  output logic                        fold_o,
  output logic                        capture_o,
  output logic                        cmp_en_o,
  output logic                        done_o,
  output logic                        alert_o
);

  localparam int unsigned CntW = $clog2(RomDepth);

  localparam int unsigned LastAddrInt = RomDepth - 1;
  localparam int unsigned DataEndInt  = RomDepth - NumDigestWords;
  localparam int unsigned LastIdxInt  = NumDigestWords - 1;

  localparam logic [CntW-1:0] LastAddr = LastAddrInt[CntW-1:0];
  // First address of the expected digest region
  localparam logic [CntW-1:0] DataEnd  = DataEndInt[CntW-1:0];
  localparam logic [CntW-1:0] LastIdx  = LastIdxInt[CntW-1:0];

  check_state_e state_q, state_d;

  logic fold_q, capture_q;
  logic alert_q;
  logic fsm_alert, start_alert, idle_cnt_alert, done_cnt_alert;

  // Next state and counter control
  always_comb begin
    state_d    = state_q;
    cnt_clr_o  = 1'b0;
    cnt_incr_o = 1'b0;
    fsm_alert  = 1'b0;
    unique case (state_q)
      Idle: begin
        if (start_i) begin
          state_d = Reading;
        end
      end
      Reading: begin
        // Last request goes out, counter restarts for the compare
        if (cnt_i == LastAddr) begin
          cnt_clr_o = 1'b1;
          state_d   = Flush;
        end else begin
          cnt_incr_o = 1'b1;
        end
      end
      Flush: begin
        // Last ROM word is on the bus this cycle
        state_d = Checking;
      end
      Checking: begin
        if (cnt_i == LastIdx) begin
          state_d = Done;
        end else begin
          cnt_incr_o = 1'b1;
        end
      end
      Done: begin
        // Stays here until reset
      end
      default: begin
        fsm_alert = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign rom_req_o = (state_q == Reading);
  assign cmp_en_o  = (state_q == Checking);
  assign done_o    = (state_q == Done);

  // Request type delayed to line up with the ROM response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fold_q    <= 1'b0;
      capture_q <= 1'b0;
    end else begin
      fold_q    <= rom_req_o && (cnt_i < DataEnd);
      capture_q <= rom_req_o && (cnt_i >= DataEnd);
    end
  end

  assign fold_o    = fold_q;
  assign capture_o = capture_q;

  // Start only makes sense from Idle
  assign start_alert    = start_i && (state_q != Idle);
  // Counter must be parked at zero before a run
  assign idle_cnt_alert = (state_q == Idle) && (cnt_i != '0);
  // Compare walk ends on the last lane
  assign done_cnt_alert = (state_q == Done) && (cnt_i != LastIdx);

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | fsm_alert | start_alert | idle_cnt_alert |
                 done_cnt_alert | cnt_err_i;
    end
  end

  assign alert_o = alert_q;

  // No ROM traffic left in flight once the result is reported
  NoReqInDone_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |-> !rom_req_o && !fold_o && !capture_o
  ) else $error("ROM traffic while done");

  // Compare index from the counter stays within the digest lanes
  CmpIdxInRange_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmp_en_o |-> (cnt_i <= LastIdx)
  ) else $error("compare index beyond last digest lane");

endmodule

`default_nettype wire

/* hdl/rom_check_pkg.sv */
/*
  Types shared by the ROM checker datapath and control.
  Holds the ROM word type, the checker state encoding and the
  command that carries returned ROM data into the digest fold.
*/
`default_nettype none

package rom_check_pkg;

  // One ROM word, also one digest lane
  typedef logic [31:0] rom_word_t;

  // Sparse state encoding
  // Five codes cannot all sit 3 apart in 5 bits, so Flush takes the
  // weak slot at distance 2 from Reading and Checking
  // All other pairs are at distance 3 or more
  typedef enum logic [4:0] {
    Idle     = 5'b00100,
    Reading  = 5'b10010,
    Flush    = 5'b11110,
    Checking = 5'b01111,
    Done     = 5'b11001
  } check_state_e;

  // Returned ROM word plus what to do with it
  // fold    word is part of the data region
  // capture word is one of the expected digest words
  typedef struct packed {
    logic      fold;
    logic      capture;
    rom_word_t data;
  } rom_load_cmd_t;

endpackage

`default_nettype wire

/* hdl/rom_check_top.sv */
/*
  Top of the boot-time ROM integrity checker.
  Pulse start_i once, serve rom_req_o with data one cycle later,
  then read good_o when done_o is high.
*/
`default_nettype none

module rom_check_top
  import rom_check_pkg::*;
  import rom_mubi_pkg::*;
#(
  parameter int unsigned RomDepth       = 16,
  parameter int unsigned NumDigestWords = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  rom_word_t                    rom_rdata_i,
  output logic                         rom_req_o,
  output logic [$clog2(RomDepth)-1:0]  rom_addr_o,
  output logic                         done_o,
  output mubi4_t                       good_o,
  output logic                         alert_o,
  output logic [NumDigestWords*32-1:0] digest_o,
  output logic [NumDigestWords*32-1:0] exp_digest_o
);

  localparam int unsigned CntW = $clog2(RomDepth);
  localparam int unsigned IdxW = (NumDigestWords > 1) ? $clog2(NumDigestWords) : 1;

  logic [CntW-1:0] cnt;
  logic            cnt_err, cnt_clr, cnt_incr;
  logic            fold, capture, cmp_en;
  rom_load_cmd_t   load_cmd;

  rom_check_fsm #(
    .RomDepth      (RomDepth),
    .NumDigestWords(NumDigestWords)
  ) rom_check_fsm_inst (
    .clk_i, .rst_ni, .start_i,
    .cnt_i     (cnt),
    .cnt_err_i (cnt_err),
    .cnt_clr_o (cnt_clr),
    .cnt_incr_o(cnt_incr),
    .rom_req_o,
    .fold_o    (fold),
    .capture_o (capture),
    .cmp_en_o  (cmp_en),
    .done_o,
    .alert_o
  );

  // Address while reading, lane index while checking
  rom_addr_counter #(
    .Width(CntW)
  ) rom_addr_counter_inst (
    .clk_i, .rst_ni,
    .clr_i (cnt_clr),
    .incr_i(cnt_incr),
    .cnt_o (cnt),
    .err_o (cnt_err)
  );

  assign rom_addr_o = cnt;

  // Delayed strobes meet the returned word here
  assign load_cmd = '{fold: fold, capture: capture, data: rom_rdata_i};

  rom_digest_accum #(
    .RomDepth      (RomDepth),
    .NumDigestWords(NumDigestWords)
  ) rom_digest_accum_inst (
    .clk_i, .rst_ni,
    .load_i(load_cmd),
    .digest_o, .exp_digest_o
  );

  rom_digest_compare #(
    .NumDigestWords(NumDigestWords)
  ) rom_digest_compare_inst (
    .clk_i, .rst_ni,
    .cmp_en_i    (cmp_en),
    .idx_i       (cnt[IdxW-1:0]),
    .digest_i    (digest_o),
    .exp_digest_i(exp_digest_o),
    .good_o
  );

endmodule

`default_nettype wire

/* hdl/rom_digest_accum.sv */
/*
  Digest datapath of the ROM checker.
  Data words are folded lane by lane with a rotate and xor.
  Expected digest words are captured in address order, so
  lane 0 holds the lowest expected-digest address.
*/
`default_nettype none

module rom_digest_accum
  import rom_check_pkg::*;
#(
  parameter int unsigned RomDepth       = 16,
  parameter int unsigned NumDigestWords = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  rom_load_cmd_t                load_i,
  output logic [NumDigestWords*32-1:0] digest_o,
  output logic [NumDigestWords*32-1:0] exp_digest_o
);

  localparam int unsigned PtrW        = (NumDigestWords > 1) ? $clog2(NumDigestWords) : 1;
  localparam int unsigned LastLaneInt = NumDigestWords - 1;
  localparam logic [PtrW-1:0] LastLane = LastLaneInt[PtrW-1:0];

  rom_word_t       digest_q     [NumDigestWords];
  rom_word_t       exp_digest_q [NumDigestWords];
  logic [PtrW-1:0] fold_ptr_q, cap_ptr_q;

  // Digest has to fit below the top of the ROM
  initial begin
    assert (NumDigestWords >= 1 && NumDigestWords < RomDepth)
      else $fatal(1, "NumDigestWords out of range");
  end

  // Fold into lane p and move on, wrapping at the last lane
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fold_ptr_q <= '0;
      for (int i = 0; i < NumDigestWords; i++) begin
        digest_q[i] <= '0;
      end
    end else if (load_i.fold) begin
      digest_q[fold_ptr_q] <= {digest_q[fold_ptr_q][30:0], digest_q[fold_ptr_q][31]} ^
                              load_i.data;
      fold_ptr_q           <= (fold_ptr_q == LastLane) ? '0 : fold_ptr_q + 1'b1;
    end
  end

  // Capture pointer, control only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_ptr_q <= '0;
    end else if (load_i.capture) begin
      cap_ptr_q <= (cap_ptr_q == LastLane) ? '0 : cap_ptr_q + 1'b1;
    end
  end

  // Expected words themselves
  always_ff @(posedge clk_i) begin
    if (load_i.capture) begin
      exp_digest_q[cap_ptr_q] <= load_i.data;
    end
  end

  // Flatten, word 0 at the LSB
  for (genvar g = 0; g < NumDigestWords; g++) begin : gen_flat
    assign digest_o[32*g +: 32]     = digest_q[g];
    assign exp_digest_o[32*g +: 32] = exp_digest_q[g];
  end

  // Control marks each returned word as one kind only
  FoldCaptureExclusive_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(load_i.fold && load_i.capture)
  ) else $error("fold and capture both high");

endmodule

`default_nettype wire

/* hdl/rom_digest_compare.sv */
/*
  Word by word compare of computed and expected digest.
  One lane per cmp_en_i cycle, lane chosen by idx_i.
  The result leaves as a registered multi-bit boolean.
*/
`default_nettype none

module rom_digest_compare
  import rom_check_pkg::*;
  import rom_mubi_pkg::*;
#(
  parameter int unsigned NumDigestWords = 2
) (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic                                                        cmp_en_i,
  input  logic [(NumDigestWords > 1 ? $clog2(NumDigestWords) : 1)-1:0] idx_i,
  input  logic [NumDigestWords*32-1:0]                                digest_i,
  input  logic [NumDigestWords*32-1:0]                                exp_digest_i,
  output mubi4_t                                                      good_o
);

  rom_word_t digest_word, exp_word;
  logic      match_q, match_d;
  mubi4_t    good_q;

  // Lane select
  assign digest_word = digest_i[32*idx_i +: 32];
  assign exp_word    = exp_digest_i[32*idx_i +: 32];

  // One bad lane is enough to fail the whole check
  assign match_d = match_q && (digest_word == exp_word);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      match_q <= 1'b1;
    end else if (cmp_en_i) begin
      match_q <= match_d;
    end
  end

  // Takes match_d so the last lane counts on the cycle Done is entered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      good_q <= MuBi4False;
    end else if (cmp_en_i) begin
      good_q <= mubi4_from_bool(match_d);
    end
  end

  assign good_o = good_q;

endmodule

`default_nettype wire

/* hdl/rom_mubi_pkg.sv */
/*
  Multi-bit boolean encoding used for the check result.
  A single flipped bit never turns false into true.
  Import it wherever a 4-bit boolean is produced or decoded.
*/
`default_nettype none

package rom_mubi_pkg;

  // Four-bit boolean, only two of the sixteen codes are valid
  typedef logic [3:0] mubi4_t;

  localparam mubi4_t MuBi4True  = 4'h6;
  localparam mubi4_t MuBi4False = 4'h9;

  // Map a plain bit onto the multi-bit encoding
  function automatic mubi4_t mubi4_from_bool(logic val);
    return val ? MuBi4True : MuBi4False;
  endfunction

  // Strict decode, any invalid code reads as false
  function automatic logic mubi4_test_true(mubi4_t val);
    return val == MuBi4True;
  endfunction

endpackage

`default_nettype wire

/* list.f */
+incdir+tb
hdl/rom_mubi_pkg.sv
hdl/rom_check_pkg.sv
hdl/rom_addr_counter.sv
hdl/rom_check_fsm.sv
hdl/rom_digest_accum.sv
hdl/rom_digest_compare.sv
hdl/rom_check_top.sv
tb/rom_check_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ROM checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Mdir obj_dir --top-module rom_check_tb -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vrom_check_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0

/* tb/rom_check_tests.svh */
/*
  Directed tests and the reference digest model for the ROM checker.
  Included inside the testbench module and uses its signals directly.
*/
`ifndef ROM_CHECK_TESTS_SVH
`define ROM_CHECK_TESTS_SVH
`default_nettype none

  task automatic check_val(input string name, input logic [DigW-1:0] got,
                           input logic [DigW-1:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      error_cnt++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Five cycles of reset, released on a rising edge
  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni  <= 1'b0;
    start_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // Lane-wise rotate-left-by-one and xor over the data region
  task automatic compute_model();
    rom_word_t lane [NumDigestWords];
    int        p;
    for (int i = 0; i < NumDigestWords; i++) begin
      lane[i] = '0;
    end
    p = 0;
    for (int a = 0; a < RomDepth - NumDigestWords; a++) begin
      lane[p] = {lane[p][30:0], lane[p][31]} ^ rom_mem[a];
      p = (p + 1) % NumDigestWords;
    end
    for (int i = 0; i < NumDigestWords; i++) begin
      model_digest[32*i +: 32] = lane[i];
    end
  endtask

  // Random data words, top of ROM holds the matching digest
  task automatic fill_random_rom();
    for (int a = 0; a < RomDepth - NumDigestWords; a++) begin
      rom_mem[a] = $urandom();
    end
    compute_model();
    for (int i = 0; i < NumDigestWords; i++) begin
      rom_mem[RomDepth - NumDigestWords + i] = model_digest[32*i +: 32];
    end
  endtask

  // One start pulse, optional second pulse on cycle restart_at
  // Checks request order, request count and done latency
  task automatic run_check(input int restart_at);
    int cyc;
    int req_cnt;
    int exp_addr;
    cyc      = 0;
    req_cnt  = 0;
    exp_addr = 0;
    @(posedge clk_i);
    start_i <= 1'b1;
    while (!done_o) begin
      @(posedge clk_i);
      cyc++;
      start_i <= (cyc == restart_at);
      @(negedge clk_i);
      if (rom_req_o) begin
        check_val("rom_addr_o", DigW'(rom_addr_o), DigW'(exp_addr));
        exp_addr++;
        req_cnt++;
      end
    end
    check_val("done_o latency", DigW'(cyc), DigW'(RunCycles));
    check_val("rom_req_o cycles", DigW'(req_cnt), DigW'(RomDepth));
  endtask

  task automatic test_reset_values();
    apply_reset();
    @(negedge clk_i);
    check_val("rom_req_o", DigW'(rom_req_o), DigW'(0));
    check_val("done_o", DigW'(done_o), DigW'(0));
    check_val("alert_o", DigW'(alert_o), DigW'(0));
    check_val("good_o", DigW'(good_o), DigW'(4'h9));
  endtask

  task automatic test_good_rom();
    fill_random_rom();
    apply_reset();
    run_check(0);
    check_val("good_o", DigW'(good_o), DigW'(4'h6));
    check_val("digest_o", digest_o, model_digest);
    check_val("exp_digest_o", exp_digest_o, model_digest);
    check_val("alert_o", DigW'(alert_o), DigW'(0));
  endtask

  // Expected words stay at the clean digest
  task automatic test_data_bitflip();
    int addr;
    int bit_pos;
    fill_random_rom();
    addr    = int'($urandom_range(RomDepth - NumDigestWords - 1, 0));
    bit_pos = int'($urandom_range(31, 0));
    rom_mem[addr][bit_pos] = ~rom_mem[addr][bit_pos];
    compute_model();
    apply_reset();
    run_check(0);
    check_val("good_o", DigW'(good_o), DigW'(4'h9));
    check_val("digest_o", digest_o, model_digest);
  endtask

  // Only the last lane differs
  task automatic test_bad_last_expected();
    fill_random_rom();
    rom_mem[RomDepth-1] = ~rom_mem[RomDepth-1];
    apply_reset();
    run_check(0);
    check_val("good_o", DigW'(good_o), DigW'(4'h9));
    check_val("digest_o", digest_o, model_digest);
  endtask

  task automatic test_restart_alert();
    fill_random_rom();
    apply_reset();
    run_check(4);
    check_val("alert_o", DigW'(alert_o), DigW'(1));
    repeat (3) @(negedge clk_i);
    check_val("alert_o", DigW'(alert_o), DigW'(1));
  endtask

`default_nettype wire
`endif

/* tb/rom_check_tb.sv */
/*
  Testbench for the ROM integrity checker.
  Holds a synchronous ROM model that answers one cycle after each
  request, the DUT, a watchdog and the error counts.
  The directed tests come from the included test file.
*/
`default_nettype none

module rom_check_tb
  import rom_check_pkg::*;
();

  localparam int unsigned RomDepth       = 16;
  localparam int unsigned NumDigestWords = 2;
  localparam int unsigned CntW           = $clog2(RomDepth);
  localparam int unsigned DigW           = NumDigestWords * 32;
  // Edge that launches start_i up to the first cycle of done_o
  localparam int unsigned RunCycles      = RomDepth + NumDigestWords + 2;
  localparam int unsigned TimeoutCycles  = 6 * (RomDepth + NumDigestWords + 20);

  logic            clk_i;
  logic            rst_ni;
  logic            start_i;
  rom_word_t       rom_rdata;
  logic            rom_req_o;
  logic [CntW-1:0] rom_addr_o;
  logic            done_o;
  logic [3:0]      good_o;
  logic            alert_o;
  logic [DigW-1:0] digest_o;
  logic [DigW-1:0] exp_digest_o;

  // ROM image and reference digest
  rom_word_t       rom_mem [RomDepth];
  logic [DigW-1:0] model_digest;

  int check_cnt;
  int error_cnt;
  int cycle_cnt;

  rom_check_top #(
    .RomDepth      (RomDepth),
    .NumDigestWords(NumDigestWords)
  ) rom_check_top_inst (
    .clk_i, .rst_ni, .start_i,
    .rom_rdata_i(rom_rdata),
    .rom_req_o, .rom_addr_o, .done_o, .good_o, .alert_o,
    .digest_o, .exp_digest_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Synchronous ROM, data one cycle after the request
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rom_rdata <= '0;
    end else if (rom_req_o) begin
      rom_rdata <= rom_mem[rom_addr_o];
    end
  end

  // Watchdog sized from the six test runs
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_ni    <= 1'b0;
    start_i   <= 1'b0;
    check_cnt = 0;
    error_cnt = 0;
    void'($urandom(72));
    test_reset_values();
    test_good_rom();
    test_data_bitflip();
    test_bad_last_expected();
    test_restart_alert();
    // Alert must be gone after a fresh reset
    test_reset_values();
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

`include "rom_check_tests.svh"

endmodule

`default_nettype wire
